/* rtl/busmaster_pkg.sv */
package busmaster_pkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	localparam int BUS_AW = 32;
	localparam int BUS_DW = 32;
	// One select per data byte
	localparam int SEL_W = BUS_DW / 8;

	typedef logic [BUS_DW-1:0] bus_word_t;
	// Word address, no byte bits
	typedef logic [BUS_AW-1:0] bus_addr_t;

	// External RAM window, 64M words
	localparam int RAM_AW = 26;

	////////////////////////////////////////
	// Device index
	////////////////////////////////////////

	// Position of each device in select and ack vectors
	typedef enum logic [1:0] {
		DEV_RAM = 2'd0,
		DEV_MEM = 2'd1,
		DEV_IO  = 2'd2
	} dev_e;

	localparam int NUM_DEV = 3;

	////////////////////////////////////////
	// I/O register map
	////////////////////////////////////////

	// Word offsets inside the fast I/O block
	localparam logic [1:0] IO_REG_SW      = 2'd0;
	localparam logic [1:0] IO_REG_LED     = 2'd1;
	localparam logic [1:0] IO_REG_ERRADDR = 2'd2;

	// Board I/O widths
	localparam int LED_W = 4;
	localparam int SW_W  = 4;

endpackage

/* rtl/busmaster_top.sv */
module busmaster_top
	import busmaster_pkg::*;
#(
	parameter int MEM_AW = 10
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	// External Wishbone master
	input  logic              i_wb_cyc,
	input  logic              i_wb_stb,
	input  logic              i_wb_we,
	input  bus_addr_t         i_wb_addr,
	input  bus_word_t         i_wb_data,
	input  logic [SEL_W-1:0]  i_wb_sel,
	output logic              o_wb_ack,
	output logic              o_wb_stall,
	output bus_word_t         o_wb_data,
	output logic              o_wb_err,
	// External RAM window
	output logic              o_ram_cyc,
	output logic              o_ram_stb,
	output logic              o_ram_we,
	output logic [RAM_AW-1:0] o_ram_addr,
	output bus_word_t         o_ram_wdata,
	output logic [SEL_W-1:0]  o_ram_sel,
	input  logic              i_ram_ack,
	input  logic              i_ram_stall,
	input  bus_word_t         i_ram_rdata,
	input  logic              i_ram_err,
	// Board I/O
	input  logic [SW_W-1:0]   i_sw,
	output logic [LED_W-1:0]  o_led
);
	logic [NUM_DEV-1:0] dev_sel;
	logic               decode_err;
	logic               slow_ack;
	logic               slow_many_ack;
	logic               fast_many_ack;
	bus_word_t          slow_data;
	bus_word_t          slow_in [1];
	logic [NUM_DEV-1:0] fast_ack;
	bus_word_t          fast_in [NUM_DEV];
	bus_addr_t          err_addr;

	wb_slave_if #(.AW(MEM_AW)) mem_bus ();
	wb_slave_if #(.AW($bits(IO_REG_ERRADDR))) io_bus ();

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	wb_addr_decode #(.MEM_AW(MEM_AW)) u_decode (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_cyc        (i_wb_cyc),
		.i_stb        (i_wb_stb),
		.i_addr       (i_wb_addr),
		.o_sel        (dev_sel),
		.o_decode_err (decode_err)
	);

	////////////////////////////////////////
	// Request fan-out
	////////////////////////////////////////

	// On-chip memory
	assign mem_bus.stb   = i_wb_stb && dev_sel[DEV_MEM];
	assign mem_bus.we    = i_wb_we;
	assign mem_bus.addr  = i_wb_addr[MEM_AW-1:0];
	assign mem_bus.wdata = i_wb_data;
	assign mem_bus.sel   = i_wb_sel;

	// Fast I/O registers
	assign io_bus.stb   = i_wb_stb && dev_sel[DEV_IO];
	assign io_bus.we    = i_wb_we;
	assign io_bus.addr  = i_wb_addr[$bits(IO_REG_ERRADDR)-1:0];
	assign io_bus.wdata = i_wb_data;
	assign io_bus.sel   = i_wb_sel;

	// RAM window, strobe combinational with the request
	assign o_ram_cyc   = i_wb_cyc;
	assign o_ram_stb   = i_wb_stb && dev_sel[DEV_RAM];
	assign o_ram_we    = i_wb_we;
	assign o_ram_addr  = i_wb_addr[RAM_AW-1:0];
	assign o_ram_wdata = i_wb_data;
	assign o_ram_sel   = i_wb_sel;

	// Stall of the addressed device only, never registered
	assign o_wb_stall = i_wb_cyc && ((dev_sel[DEV_RAM] && i_ram_stall)
		|| (dev_sel[DEV_MEM] && mem_bus.stall)
		|| (dev_sel[DEV_IO] && io_bus.stall));

	////////////////////////////////////////
	// Slaves
	////////////////////////////////////////

	wb_blkram #(.MEM_AW(MEM_AW)) u_blkram (
		.i_clk (i_clk),
		.bus   (mem_bus)
	);

	wb_fastio u_fastio (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_sw       (i_sw),
		.i_err_addr (err_addr),
		.bus        (io_bus),
		.o_led      (o_led)
	);

	////////////////////////////////////////
	// Return path
	////////////////////////////////////////

	// Slow group, one extra clock
	assign slow_in[0] = io_bus.rdata;

	wb_ack_merge #(.N(1)) u_slow_merge (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_cyc      (i_wb_cyc),
		.i_ack      (io_bus.ack),
		.i_data     (slow_in),
		.o_ack      (slow_ack),
		.o_data     (slow_data),
		.o_many_ack (slow_many_ack)
	);

	// Final merge, slow result in the I/O slot
	assign fast_ack[DEV_RAM] = i_ram_ack;
	assign fast_ack[DEV_MEM] = mem_bus.ack;
	assign fast_ack[DEV_IO]  = slow_ack;
	assign fast_in[DEV_RAM]  = i_ram_rdata;
	assign fast_in[DEV_MEM]  = mem_bus.rdata;
	assign fast_in[DEV_IO]   = slow_data;

	wb_ack_merge #(.N(NUM_DEV)) u_fast_merge (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_cyc      (i_wb_cyc),
		.i_ack      (fast_ack),
		.i_data     (fast_in),
		.o_ack      (o_wb_ack),
		.o_data     (o_wb_data),
		.o_many_ack (fast_many_ack)
	);

	////////////////////////////////////////
	// Bus error
	////////////////////////////////////////

	wb_bus_error u_bus_error (
		.i_clk           (i_clk),
		.i_arst_n        (i_arst_n),
		.i_cyc           (i_wb_cyc),
		.i_addr          (i_wb_addr),
		.i_decode_err    (decode_err),
		.i_many_ack_slow (slow_many_ack),
		.i_many_ack_fast (fast_many_ack),
		.i_ram_err       (i_ram_err),
		.o_err           (o_wb_err),
		.o_err_addr      (err_addr)
	);

endmodule

/* rtl/wb_ack_merge.sv */
module wb_ack_merge
	import busmaster_pkg::*;
#(
	parameter int N = 3
) (
	input  logic         i_clk,
	input  logic         i_arst_n,
	input  logic         i_cyc,
	input  logic [N-1:0] i_ack,
	input  bus_word_t    i_data [N],
	output logic         o_ack,
	output bus_word_t    o_data,
	output logic         o_many_ack
);
	bus_word_t pick;

	// Word of the acking source, lowest index first
	always_comb
	begin
		pick = i_data[0];
		for (int i = N - 1; i >= 0; i--)
		begin
			if (i_ack[i])
				pick = i_data[i];
		end
	end

	////////////////////////////////////////
	// Registered return stage
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_ack      <= 1'b0;
			o_many_ack <= 1'b0;
		end
		else
		begin
			// Acks after a dropped cycle are lost
			o_ack      <= i_cyc && |i_ack;
			// Two sources answering together
			o_many_ack <= !$onehot0(i_ack);
		end
	end

	// Read word follows the ack
	always_ff @(posedge i_clk)
	begin
		o_data <= pick;
	end

	// Every source drives a known ack inside a cycle
	a_ack_known: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_cyc |-> !$isunknown(i_ack)
	);

endmodule

/* rtl/wb_addr_decode.sv */
module wb_addr_decode
	import busmaster_pkg::*;
#(
	parameter int MEM_AW = 10
) (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  logic               i_cyc,
	input  logic               i_stb,
	input  bus_addr_t          i_addr,
	output logic [NUM_DEV-1:0] o_sel,
	output logic               o_decode_err
);
	// Offset bits of the 32k word memory window above MEM_AW
	localparam logic [14:0] MEM_HI_MASK = ~((15'd1 << MEM_AW) - 15'd1);

	logic [4:0] skip;
	logic       hi_clear;
	logic       none_q;

	////////////////////////////////////////
	// Skip bits
	////////////////////////////////////////

	// RAM, flash, memory, net, I/O page (bit 8 inverted)
	assign skip = {i_addr[26], i_addr[22], i_addr[15], i_addr[11], ~i_addr[8]};

	// Bits above every window and the gap under the RAM bit
	assign hi_clear = ~|i_addr[31:27] && ~|i_addr[25:23];

	////////////////////////////////////////
	// Device selects
	////////////////////////////////////////

	// Only legal addresses select, so the selects are one-hot by construction
	assign o_sel[DEV_RAM] = hi_clear && skip[4];

	// Block RAM, no flash bit, unused offset bits clear
	assign o_sel[DEV_MEM] = hi_clear && (skip[4:2] == 3'b001)
		&& ~|i_addr[21:16]
		&& ~|(i_addr[14:0] & MEM_HI_MASK);

	// I/O page, first 32 words, only the mapped registers
	assign o_sel[DEV_IO] = hi_clear && (skip == 5'b00000)
		&& ~|i_addr[21:16]
		&& ~|i_addr[14:12]
		&& ~|i_addr[10:9]
		&& ~|i_addr[7:5]
		&& (i_addr[4:0] <= {3'b000, IO_REG_ERRADDR});

	////////////////////////////////////////
	// Decode error
	////////////////////////////////////////

	// Strobe that found no device, flagged the cycle after
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			none_q <= 1'b0;
		else
			none_q <= i_cyc && i_stb && ~|o_sel;
	end

	assign o_decode_err = none_q;

	// A strobe never reaches two devices
	a_sel_onehot: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		i_stb |-> $onehot0(o_sel)
	);

endmodule

/* rtl/wb_blkram.sv */
module wb_blkram
	import busmaster_pkg::*;
#(
	parameter int MEM_AW = 10
) (
	input  logic       i_clk,
	wb_slave_if.slave  bus
);
	bus_word_t mem [2**MEM_AW];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	// Byte lanes under their selects
	always_ff @(posedge i_clk)
	begin
		if (bus.stb && bus.we)
		begin
			for (int b = 0; b < SEL_W; b++)
			begin
				if (bus.sel[b])
					mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
	end

	////////////////////////////////////////
	// Read and ack
	////////////////////////////////////////

	// Old contents on a write, ignored by the master anyway
	always_ff @(posedge i_clk)
	begin
		bus.rdata <= mem[bus.addr];
	end

	// Answer one clock after the strobe
	always_ff @(posedge i_clk)
	begin
		bus.ack <= bus.stb;
	end

	// One word per clock, always ready
	assign bus.stall = 1'b0;

endmodule

/* rtl/wb_bus_error.sv */
module wb_bus_error
	import busmaster_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  logic      i_cyc,
	input  bus_addr_t i_addr,
	input  logic      i_decode_err,
	input  logic      i_many_ack_slow,
	input  logic      i_many_ack_fast,
	input  logic      i_ram_err,
	output logic      o_err,
	output bus_addr_t o_err_addr
);
	bus_addr_t addr_q;

	// Address of the request that the registered decode error refers to
	always_ff @(posedge i_clk)
	begin
		addr_q <= i_addr;
	end

	// RAM error passes straight through, the rest are already registered
	assign o_err = i_cyc && (i_decode_err || i_many_ack_slow
		|| i_many_ack_fast || i_ram_err);

	// Last failing address, for the I/O block readback
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_err_addr <= '0;
		else if (o_err)
			o_err_addr <= addr_q;
	end

endmodule

/* rtl/wb_fastio.sv */
module wb_fastio
	import busmaster_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic [SW_W-1:0]  i_sw,
	input  bus_addr_t        i_err_addr,
	wb_slave_if.slave        bus,
	output logic [LED_W-1:0] o_led
);
	bus_word_t rd_word;

	////////////////////////////////////////
	// LED register
	////////////////////////////////////////

	// Low byte lane only
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_led <= '0;
		else if (bus.stb && bus.we && bus.sel[0] && (bus.addr == IO_REG_LED))
			o_led <= bus.wdata[LED_W-1:0];
	end

	////////////////////////////////////////
	// Readback
	////////////////////////////////////////

	always_comb
	begin
		case (bus.addr)
			IO_REG_SW:      rd_word = bus_word_t'(i_sw);
			IO_REG_LED:     rd_word = bus_word_t'(o_led);
			// Read only, writes fall on the floor
			IO_REG_ERRADDR: rd_word = i_err_addr;
			default:        rd_word = '0;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		bus.rdata <= rd_word;
	end

	// Single cycle answer
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.stb;
	end

	assign bus.stall = 1'b0;

endmodule

/* rtl/wb_slave_if.sv */
interface wb_slave_if
	import busmaster_pkg::*;
#(
	parameter int AW = 10
) ();
	// Request, from the interconnect
	logic             stb;
	logic             we;
	logic [AW-1:0]    addr;
	bus_word_t        wdata;
	logic [SEL_W-1:0] sel;

	// Response, from the slave
	logic             ack;
	logic             stall;
	bus_word_t        rdata;

	// Interconnect side
	modport master (
		output stb, we, addr, wdata, sel,
		input  ack, stall, rdata
	);

	// Device side
	modport slave (
		input  stb, we, addr, wdata, sel,
		output ack, stall, rdata
	);

endinterface

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_busmaster -o tb_busmaster

out=$(./obj_dir/tb_busmaster)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
	exit 0
else
	exit 1
fi

/* testbench/busmaster_stim.txt */
# name op addr data sel sw expected_read expect_err (hex except the last column)
# op: wr write, rd read, bu burst read without waiting, re RAM read with injected error
mem_wr_full   wr 00008010 11223344 f 0 00000000 0
mem_wr_bytes  wr 00008010 aabbccdd 5 0 00000000 0
mem_rd_merged rd 00008010 00000000 f 0 11bb33dd 0
mem_wr_1      wr 00008011 01010101 f 0 00000000 0
mem_wr_2      wr 00008012 02020202 f 0 00000000 0
mem_wr_3      wr 00008013 03030303 f 0 00000000 0
burst_rd_0    bu 00008010 00000000 f 0 11bb33dd 0
burst_rd_1    bu 00008011 00000000 f 0 01010101 0
burst_rd_2    bu 00008012 00000000 f 0 02020202 0
burst_rd_3    rd 00008013 00000000 f 0 03030303 0
led_wr        wr 00000101 000000a5 1 0 00000000 0
led_rd        rd 00000101 00000000 f 0 00000005 0
sw_rd         rd 00000100 00000000 f b 0000000b 0
err_hi_bit    wr 08000000 12345678 f 0 00000000 1
err_flash     rd 00400000 00000000 f 0 00000000 1
err_mem_gap   rd 00008400 00000000 f 0 00000000 1
erraddr_rd_1  rd 00000102 00000000 f 0 00008400 0
err_io_reg    rd 00000103 00000000 f 0 00000000 1
err_ram_gap   rd 04800000 00000000 f 0 00000000 1
erraddr_rd_2  rd 00000102 00000000 f 0 04800000 0
ram_wr        wr 04000123 deadbeef f 0 00000000 0
ram_rd        rd 04000123 00000000 f 0 deadbeef 0
ram_err       re 04000040 00000000 f 0 00000000 1

/* testbench/tb_busmaster.sv */
module tb_busmaster
	import busmaster_pkg::*;
();
	localparam int MEM_AW = 10;
	// Clock cycles that any single wait may take
	localparam int WAIT_LIMIT = 200;

	logic              i_clk;
	logic              i_arst_n;
	logic              i_wb_cyc;
	logic              i_wb_stb;
	logic              i_wb_we;
	bus_addr_t         i_wb_addr;
	bus_word_t         i_wb_data;
	logic [SEL_W-1:0]  i_wb_sel;
	logic              o_wb_ack;
	logic              o_wb_stall;
	bus_word_t         o_wb_data;
	logic              o_wb_err;
	logic              o_ram_cyc;
	logic              o_ram_stb;
	logic              o_ram_we;
	logic [RAM_AW-1:0] o_ram_addr;
	bus_word_t         o_ram_wdata;
	logic [SEL_W-1:0]  o_ram_sel;
	logic              i_ram_ack = 1'b0;
	logic              i_ram_stall = 1'b0;
	bus_word_t         i_ram_rdata = '0;
	logic              i_ram_err = 1'b0;
	logic [SW_W-1:0]   i_sw;
	logic [LED_W-1:0]  o_led;

	// Stim lines, driver side
	string             op_q [$];
	bus_addr_t         addr_q [$];
	bus_word_t         data_q [$];
	logic [SEL_W-1:0]  sel_q [$];
	logic [SW_W-1:0]   sw_q [$];

	logic              abort;
	logic              ram_err_req;
	int                acc_cnt;
	int                resp_cnt = 0;
	int                pass_cnt;
	int                fail_cnt;

	// External RAM model state
	bus_word_t         ram_mem [256];
	int                ram_wait = 0;
	logic              req_err = 1'b0;
	bus_word_t         req_rdata = '0;

	busmaster_top #(.MEM_AW(MEM_AW)) UUT (.*);

	tb_checker u_checker (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_ack      (o_wb_ack),
		.i_err      (o_wb_err),
		.i_data     (o_wb_data),
		.i_ram_stb  (o_ram_stb),
		.i_ram_addr (o_ram_addr),
		.i_led      (o_led),
		.o_pass_cnt (pass_cnt),
		.o_fail_cnt (fail_cnt)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// External RAM model
	////////////////////////////////////////

	// Accept, store the write, count the latency down
	always @(posedge i_clk)
	begin
		if (!i_arst_n)
			ram_wait <= 0;
		else if (o_ram_cyc && o_ram_stb && !i_ram_stall)
		begin
			ram_wait  <= 1 + int'($urandom % 4);
			req_err   <= ram_err_req;
			req_rdata <= ram_mem[o_ram_addr[7:0]];
			for (int b = 0; b < SEL_W; b++)
			begin
				if (o_ram_we && o_ram_sel[b])
					ram_mem[o_ram_addr[7:0]][8*b +: 8] <= o_ram_wdata[8*b +: 8];
			end
		end
		else if (ram_wait > 0)
			ram_wait <= ram_wait - 1;
	end

	// Random stall, answer on the last wait cycle
	always @(negedge i_clk)
	begin
		i_ram_stall <= i_arst_n && (($urandom % 3) == 0);
		i_ram_ack   <= (ram_wait == 1) && !req_err;
		i_ram_err   <= (ram_wait == 1) && req_err;
		i_ram_rdata <= req_rdata;
	end

	// Every ack or err seen at the bus
	always @(posedge i_clk)
	begin
		if (i_arst_n && (o_wb_ack || o_wb_err))
			resp_cnt <= resp_cnt + 1;
	end

	////////////////////////////////////////
	// Driver
	////////////////////////////////////////

	task automatic load_stim();
		int        fd;
		int        n;
		int        err;
		string     line;
		string     name;
		string     op;
		bus_addr_t a;
		bus_word_t d;
		bus_word_t e;
		logic [SEL_W-1:0] s;
		logic [SW_W-1:0]  w;
		fd = $fopen("testbench/busmaster_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file");
			abort = 1'b1;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank and comment lines
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %s %h %h %h %h %h %d", name, op, a, d, s, w, e, err);
				if (n == 8)
				begin
					op_q.push_back(op);
					addr_q.push_back(a);
					data_q.push_back(d);
					sel_q.push_back(s);
					sw_q.push_back(w);
				end
			end
			$fclose(fd);
		end
	endtask

	// One request, held while the target stalls
	task automatic issue(input int k);
		int   n;
		logic taken;
		n = 0;
		taken = 1'b0;
		i_wb_stb    = 1'b1;
		i_wb_we     = (op_q[k] == "wr");
		i_wb_addr   = addr_q[k];
		i_wb_data   = data_q[k];
		i_wb_sel    = sel_q[k];
		i_sw        = sw_q[k];
		ram_err_req = (op_q[k] == "re");
		while (!taken && !abort)
		begin
			@(posedge i_clk);
			n = n + 1;
			if (!o_wb_stall)
				taken = 1'b1;
			else if (n > WAIT_LIMIT)
			begin
				$display("Request %0d stayed stalled too long", k);
				abort = 1'b1;
			end
		end
		if (taken)
			acc_cnt = acc_cnt + 1;
		@(negedge i_clk);
		i_wb_stb    = 1'b0;
		ram_err_req = 1'b0;
	endtask

	// Until every accepted request has its answer
	task automatic wait_idle();
		int n;
		n = 0;
		while (resp_cnt < acc_cnt && !abort)
		begin
			@(negedge i_clk);
			n = n + 1;
			if (n > WAIT_LIMIT)
			begin
				$display("Timeout waiting for the response to request %0d", acc_cnt - 1);
				abort = 1'b1;
			end
		end
	endtask

	initial
	begin
		void'($urandom(64192));
		abort       = 1'b0;
		acc_cnt     = 0;
		ram_err_req = 1'b0;
		i_arst_n    = 1'b0;
		i_wb_cyc    = 1'b0;
		i_wb_stb    = 1'b0;
		i_wb_we     = 1'b0;
		i_wb_addr   = '0;
		i_wb_data   = '0;
		i_wb_sel    = '0;
		i_sw        = '0;
		load_stim();
		repeat (2) @(negedge i_clk);
		i_arst_n = 1'b1;
		@(negedge i_clk);
		i_wb_cyc = 1'b1;
		// Burst lines go out back to back
		for (int k = 0; k < op_q.size() && !abort; k++)
		begin
			issue(k);
			if (op_q[k] != "bu")
				wait_idle();
		end
		i_wb_cyc = 1'b0;
		$display("Tests %0d, passed %0d, failed %0d", op_q.size(), pass_cnt, fail_cnt);
		if (!abort && op_q.size() > 0 && fail_cnt == 0 && pass_cnt == op_q.size())
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* testbench/tb_checker.sv */
module tb_checker
	import busmaster_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_ack,
	input  logic              i_err,
	input  bus_word_t         i_data,
	input  logic              i_ram_stb,
	input  logic [RAM_AW-1:0] i_ram_addr,
	input  logic [LED_W-1:0]  i_led,
	output int                o_pass_cnt,
	output int                o_fail_cnt
);
	// LED register inside the I/O page
	localparam bus_addr_t LED_ADDR = 32'h0000_0100 | bus_addr_t'(IO_REG_LED);

	// Expectations, in response order
	string             name_q [$];
	string             op_q [$];
	bus_addr_t         addr_q [$];
	bus_word_t         exp_q [$];
	logic              err_q [$];

	int                idx;
	logic              addr_bad;
	logic [RAM_AW-1:0] addr_exp;
	logic [RAM_AW-1:0] addr_got;

	initial
	begin : load
		int        fd;
		int        n;
		int        err;
		string     line;
		string     name;
		string     op;
		bus_addr_t a;
		bus_word_t d;
		bus_word_t e;
		logic [SEL_W-1:0] s;
		logic [SW_W-1:0]  w;
		fd = $fopen("testbench/busmaster_stim.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %s %h %h %h %h %h %d", name, op, a, d, s, w, e, err);
				if (n == 8)
				begin
					name_q.push_back(name);
					op_q.push_back(op);
					addr_q.push_back(a);
					exp_q.push_back(e);
					err_q.push_back(err != 0);
				end
			end
			$fclose(fd);
		end
	end

	////////////////////////////////////////
	// Response judge
	////////////////////////////////////////

	task automatic judge();
		logic good;
		good = 1'b0;
		if (idx >= name_q.size())
			$display("A bus response arrived with no test left to match it");
		else if (i_err && !err_q[idx])
			$display("%s: bus error where an ack was expected", name_q[idx]);
		else if (i_ack && err_q[idx])
			$display("%s: ack where a bus error was expected", name_q[idx]);
		else if (addr_bad)
			$display("** Error %s: expected RAM address %h, actual %h",
				name_q[idx], addr_exp, addr_got);
		// Write acks carry no data
		else if (i_ack && op_q[idx] != "wr" && i_data !== exp_q[idx])
			$display("** Error %s: expected %h, actual %h", name_q[idx], exp_q[idx], i_data);
		// LED port shows the register that was read back
		else if (i_ack && op_q[idx] == "rd" && addr_q[idx] == LED_ADDR
			&& i_led !== exp_q[idx][LED_W-1:0])
			$display("** Error %s: expected LED port %h, actual %h",
				name_q[idx], exp_q[idx][LED_W-1:0], i_led);
		else
		begin
			good = 1'b1;
			$display("ok    %s", name_q[idx]);
		end
		if (good)
			o_pass_cnt = o_pass_cnt + 1;
		else
			o_fail_cnt = o_fail_cnt + 1;
		addr_bad = 1'b0;
		idx = idx + 1;
	endtask

	always @(posedge i_clk)
	begin
		if (!i_arst_n)
		begin
			o_pass_cnt = 0;
			o_fail_cnt = 0;
			idx        = 0;
			addr_bad   = 1'b0;
		end
		else
		begin
			// Window address is the low word address bits
			if (i_ram_stb && idx < addr_q.size()
				&& (i_ram_addr !== addr_q[idx][RAM_AW-1:0]))
			begin
				addr_bad = 1'b1;
				addr_exp = addr_q[idx][RAM_AW-1:0];
				addr_got = i_ram_addr;
			end
			if (i_ack || i_err)
				judge();
		end
	end

endmodule

/* vlog.f */
rtl/busmaster_pkg.sv
rtl/wb_slave_if.sv
rtl/wb_addr_decode.sv
rtl/wb_ack_merge.sv
rtl/wb_bus_error.sv
rtl/wb_blkram.sv
rtl/wb_fastio.sv
rtl/busmaster_top.sv
testbench/tb_checker.sv
testbench/tb_busmaster.sv
